// ==== source/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Cache geometry
// Direct mapped, one tag per line
`define DCACHE_LINES 16

// Words per cache line, also the number of beats in one fill
`define LINE_WORDS 4

// Bytes per line, used for line alignment and offset width
`define LINE_BYTES (`LINE_WORDS * 4)

// Pending stores held before they reach the cache and memory
`define SB_DEPTH 2

`endif

// ==== source/mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // One full cache line, word 0 in the low bits
    typedef logic [`LINE_WORDS*32-1:0] line_t;

    // Address split: tag above index above line offset
    typedef logic [23:0] tag_t;
    typedef logic [3:0]  index_t;

    // One bit per byte lane of a word
    typedef logic [3:0] mask_t;

    // Register file address
    typedef logic [4:0] reg_addr_t;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_size_e;

    // Line fill sequence
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        FILL,
        INSTALL
    } miss_state_e;

endpackage

// ==== source/mem_ifs.sv ====
`timescale 1ns/1ns

// Access port between the memory stage and the cache array
interface dcache_port_if;
    import mem_pkg::*;

    logic  rd_en;
    logic  wr_en;
    word_t addr;
    word_t wdata;
    mask_t wmask;
    word_t rdata;
    logic  hit;

    modport master (output rd_en, wr_en, addr, wdata, wmask, input rdata, hit);
    modport slave  (input rd_en, wr_en, addr, wdata, wmask, output rdata, hit);
endinterface

// Push, lookup and drain port of the store buffer
interface sb_port_if;
    import mem_pkg::*;

    logic  push;
    word_t push_addr;
    word_t push_data;
    mask_t push_mask;
    word_t lookup_addr;
    mask_t lookup_mask;
    logic  fwd_hit;
    word_t fwd_data;
    logic  conflict;
    logic  full;
    logic  drain_vld;
    word_t drain_addr;
    word_t drain_data;
    mask_t drain_mask;
    logic  drain_ack;

    modport master (
        output push, push_addr, push_data, push_mask, lookup_addr, lookup_mask, drain_ack,
        input  fwd_hit, fwd_data, conflict, full, drain_vld, drain_addr, drain_data, drain_mask
    );
    modport slave (
        input  push, push_addr, push_data, push_mask, lookup_addr, lookup_mask, drain_ack,
        output fwd_hit, fwd_data, conflict, full, drain_vld, drain_addr, drain_data, drain_mask
    );
endinterface

// ==== source/dcache_array.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module dcache_array (
    input  logic           clk_i,
    input  logic           rst_n_i,
    dcache_port_if.slave   port,
    input  logic           fill_we_i,
    input  mem_pkg::word_t fill_addr_i,
    input  mem_pkg::line_t fill_line_i
);
    import mem_pkg::*;

    localparam int OFFS_W = $clog2(`LINE_BYTES);
    localparam int WSEL_W = $clog2(`LINE_WORDS);

    logic [`DCACHE_LINES-1:0] valid_q;
    tag_t                     tag_q  [`DCACHE_LINES];
    line_t                    data_q [`DCACHE_LINES];

    index_t            idx;
    index_t            fill_idx;
    tag_t              tag;
    logic [WSEL_W-1:0] wsel;
    word_t             cur_word;
    word_t             new_word;

    // Address fields of the access port and of the fill
    assign idx      = port.addr[OFFS_W +: $bits(index_t)];
    assign tag      = port.addr[31 -: $bits(tag_t)];
    assign wsel     = port.addr[2 +: WSEL_W];
    assign fill_idx = fill_addr_i[OFFS_W +: $bits(index_t)];

    // Combinational lookup
    assign cur_word   = data_q[idx][wsel*32 +: 32];
    assign port.rdata = cur_word;
    assign port.hit   = (port.rd_en || port.wr_en) && valid_q[idx] && (tag_q[idx] == tag);

    // Merge drained bytes into the stored word
    always_comb begin
        new_word = cur_word;
        for (int b = 0; b < 4; b++) begin
            if (port.wmask[b]) begin
                new_word[b*8 +: 8] = port.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_we_i) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // Whole line on fill, masked word on a write hit only
    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            data_q[fill_idx] <= fill_line_i;
            tag_q[fill_idx]  <= fill_addr_i[31 -: $bits(tag_t)];
        end else if (port.wr_en && port.hit) begin
            data_q[idx][wsel*32 +: 32] <= new_word;
        end
    end

    // Fills only happen outside IDLE, drains only inside it
    a_no_fill_and_drain: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(fill_we_i && port.wr_en)
    );

endmodule

// ==== source/store_buffer.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module store_buffer (
    input  logic       clk_i,
    input  logic       rst_n_i,
    sb_port_if.slave   sb
);
    import mem_pkg::*;

    localparam int PTR_W = (`SB_DEPTH > 1) ? $clog2(`SB_DEPTH) : 1;
    localparam int CNT_W = $clog2(`SB_DEPTH + 1);

    word_t ent_addr [`SB_DEPTH];
    word_t ent_data [`SB_DEPTH];
    mask_t ent_mask [`SB_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    assign sb.full       = (count == CNT_W'(`SB_DEPTH));
    assign sb.drain_vld  = (count != '0);
    assign sb.drain_addr = ent_addr[rd_ptr];
    assign sb.drain_data = ent_data[rd_ptr];
    assign sb.drain_mask = ent_mask[rd_ptr];

    // Youngest overlapping entry decides: full cover forwards, partial cover conflicts
    always_comb begin
        int unsigned slot;
        logic        found;

        sb.fwd_hit  = 1'b0;
        sb.conflict = 1'b0;
        sb.fwd_data = '0;
        found       = 1'b0;
        for (int age = `SB_DEPTH - 1; age >= 0; age--) begin
            slot = (int'(rd_ptr) + age) % `SB_DEPTH;
            if (!found && (age < int'(count))
                && (ent_addr[slot][31:2] == sb.lookup_addr[31:2])
                && ((ent_mask[slot] & sb.lookup_mask) != '0)) begin
                found = 1'b1;
                if ((ent_mask[slot] & sb.lookup_mask) == sb.lookup_mask) begin
                    sb.fwd_hit  = 1'b1;
                    sb.fwd_data = ent_data[slot];
                end else begin
                    sb.conflict = 1'b1;
                end
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (sb.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`SB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (sb.drain_ack) begin
                rd_ptr <= (rd_ptr == PTR_W'(`SB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (sb.push && !sb.drain_ack) begin
                count <= count + 1'b1;
            end else if (!sb.push && sb.drain_ack) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sb.push) begin
            ent_addr[wr_ptr] <= sb.push_addr;
            ent_data[wr_ptr] <= sb.push_data;
            ent_mask[wr_ptr] <= sb.push_mask;
        end
    end

    // Stage stalls stores while full
    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) sb.push |-> !sb.full
    );

endmodule

// ==== source/beat_counter.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module beat_counter (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           mem_beat_vld_i,
    input  mem_pkg::word_t mem_beat_data_i,
    output mem_pkg::line_t fill_line_o,
    output logic           line_done_o
);

    localparam int CNT_W = (`LINE_WORDS > 1) ? $clog2(`LINE_WORDS) : 1;

    logic [CNT_W-1:0] cnt;

    // High together with the last beat of a line
    assign line_done_o = mem_beat_vld_i && (cnt == CNT_W'(`LINE_WORDS - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt <= '0;
        end else if (mem_beat_vld_i) begin
            cnt <= line_done_o ? '0 : cnt + 1'b1;
        end
    end

    // Beats arrive in word order, slot follows the count
    always_ff @(posedge clk_i) begin
        if (mem_beat_vld_i) begin
            fill_line_o[cnt*32 +: 32] <= mem_beat_data_i;
        end
    end

endmodule

// ==== source/miss_ctrl.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module miss_ctrl (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           miss_i,
    input  mem_pkg::word_t miss_addr_i,
    input  logic           line_done_i,
    output logic           mem_rd_req_o,
    output mem_pkg::word_t mem_rd_addr_o,
    output logic           fill_we_o,
    output mem_pkg::word_t fill_addr_o,
    output logic           idle_o
);
    import mem_pkg::*;

    miss_state_e state_q;
    miss_state_e state_d;
    word_t       line_addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (miss_i) state_d = REQ;
            REQ:     state_d = FILL;
            FILL:    if (line_done_i) state_d = INSTALL;
            INSTALL: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Line base of the held load, kept until the install
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && miss_i) begin
            line_addr_q <= miss_addr_i & ~word_t'(`LINE_BYTES - 1);
        end
    end

    assign mem_rd_req_o  = (state_q == REQ);
    assign mem_rd_addr_o = line_addr_q;
    assign fill_we_o     = (state_q == INSTALL);
    assign fill_addr_o   = line_addr_q;
    assign idle_o        = (state_q == IDLE);

    // Memory answers only requests issued from REQ
    a_done_in_fill: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) line_done_i |-> (state_q == FILL)
    );

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  mem_pkg::word_t         alu_res_i,
    input  mem_pkg::word_t         rf_st_data_i,
    input  logic                   rf_we_i,
    input  mem_pkg::reg_addr_t     rf_waddr_i,
    input  logic                   memop_rd_i,
    input  logic                   memop_wr_i,
    input  mem_pkg::memop_size_e   memop_size_i,
    input  logic                   memop_sign_ext_i,
    input  logic                   tkbr_i,
    input  mem_pkg::word_t         new_pc_i,
    output mem_pkg::word_t         op_res_o,
    output logic                   rf_we_o,
    output mem_pkg::reg_addr_t     rf_waddr_o,
    output logic                   tkbr_o,
    output mem_pkg::word_t         new_pc_o,
    output logic                   stall_o,
    output logic                   miss_o,
    input  logic                   ctrl_idle_i,
    dcache_port_if.master          dc,
    sb_port_if.master              sb
);
    import mem_pkg::*;

    logic [1:0] boff;
    word_t      word_addr;
    mask_t      acc_mask;
    logic       load_active;
    word_t      raw_data;
    word_t      shifted;
    word_t      load_data;

    assign boff      = alu_res_i[1:0];
    assign word_addr = {alu_res_i[31:2], 2'b00};

    // Byte lanes touched by the access
    always_comb begin
        case (memop_size_i)
            BYTE:    acc_mask = 4'b0001 << boff;
            HALF:    acc_mask = 4'b0011 << boff;
            default: acc_mask = 4'b1111;
        endcase
    end

    // Stores go to the buffer, shifted onto their lanes
    assign sb.push      = memop_wr_i && !sb.full;
    assign sb.push_addr = word_addr;
    assign sb.push_data = rf_st_data_i << {boff, 3'b000};
    assign sb.push_mask = acc_mask;

    assign sb.lookup_addr = word_addr;
    assign sb.lookup_mask = acc_mask;

    // A conflicting load gives the port to the drain
    assign load_active  = memop_rd_i && !sb.conflict;
    assign sb.drain_ack = sb.drain_vld && !load_active && ctrl_idle_i;

    assign dc.rd_en = load_active;
    assign dc.wr_en = sb.drain_ack;
    assign dc.addr  = load_active ? alu_res_i : sb.drain_addr;
    assign dc.wdata = sb.drain_data;
    assign dc.wmask = sb.drain_mask;

    assign miss_o  = load_active && !sb.fwd_hit && !dc.hit;
    assign stall_o = (memop_rd_i && (sb.conflict || miss_o)) || (memop_wr_i && sb.full);

    // Forwarded data wins over the cache
    assign raw_data = sb.fwd_hit ? sb.fwd_data : dc.rdata;
    assign shifted  = raw_data >> {boff, 3'b000};

    always_comb begin
        case (memop_size_i)
            BYTE:    load_data = {{24{memop_sign_ext_i & shifted[7]}}, shifted[7:0]};
            HALF:    load_data = {{16{memop_sign_ext_i & shifted[15]}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    // Writeback register, frozen while stalled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rf_we_o <= 1'b0;
            tkbr_o  <= 1'b0;
        end else if (!stall_o) begin
            rf_we_o <= rf_we_i;
            tkbr_o  <= tkbr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_o) begin
            op_res_o   <= memop_rd_i ? load_data : alu_res_i;
            rf_waddr_o <= rf_waddr_i;
            new_pc_o   <= new_pc_i;
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(memop_rd_i && memop_wr_i)
    );

    a_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (memop_rd_i || memop_wr_i) |->
            (memop_size_i == BYTE) || (memop_size_i == HALF && !boff[0]) || (boff == 2'b00)
    );

    // Pipeline keeps the access steady until the stall clears
    a_hold_on_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        stall_o |=> $stable({memop_rd_i, memop_wr_i, alu_res_i})
    );

endmodule

// ==== source/mem_top.sv ====
`timescale 1ns/1ns

module mem_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  mem_pkg::word_t       alu_res_i,
    input  mem_pkg::word_t       rf_st_data_i,
    input  logic                 rf_we_i,
    input  mem_pkg::reg_addr_t   rf_waddr_i,
    input  logic                 memop_rd_i,
    input  logic                 memop_wr_i,
    input  mem_pkg::memop_size_e memop_size_i,
    input  logic                 memop_sign_ext_i,
    input  logic                 tkbr_i,
    input  mem_pkg::word_t       new_pc_i,
    output mem_pkg::word_t       op_res_o,
    output logic                 rf_we_o,
    output mem_pkg::reg_addr_t   rf_waddr_o,
    output logic                 tkbr_o,
    output mem_pkg::word_t       new_pc_o,
    output logic                 stall_o,
    output logic                 mem_rd_req_o,
    output mem_pkg::word_t       mem_rd_addr_o,
    input  logic                 mem_beat_vld_i,
    input  mem_pkg::word_t       mem_beat_data_i,
    output logic                 mem_wr_o,
    output mem_pkg::word_t       mem_wr_addr_o,
    output mem_pkg::word_t       mem_wr_data_o,
    output mem_pkg::mask_t       mem_wr_mask_o
);
    import mem_pkg::*;

    dcache_port_if dc_port ();
    sb_port_if     sb_port ();

    logic  miss;
    logic  ctrl_idle;
    logic  fill_we;
    logic  line_done;
    word_t fill_addr;
    line_t fill_line;

    mem_stage mem_stage_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .alu_res_i        (alu_res_i),
        .rf_st_data_i     (rf_st_data_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .memop_size_i     (memop_size_i),
        .memop_sign_ext_i (memop_sign_ext_i),
        .tkbr_i           (tkbr_i),
        .new_pc_i         (new_pc_i),
        .op_res_o         (op_res_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .tkbr_o           (tkbr_o),
        .new_pc_o         (new_pc_o),
        .stall_o          (stall_o),
        .miss_o           (miss),
        .ctrl_idle_i      (ctrl_idle),
        .dc               (dc_port.master),
        .sb               (sb_port.master)
    );

    dcache_array dcache_array_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .port        (dc_port.slave),
        .fill_we_i   (fill_we),
        .fill_addr_i (fill_addr),
        .fill_line_i (fill_line)
    );

    store_buffer store_buffer_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .sb      (sb_port.slave)
    );

    beat_counter beat_counter_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .mem_beat_vld_i  (mem_beat_vld_i),
        .mem_beat_data_i (mem_beat_data_i),
        .fill_line_o     (fill_line),
        .line_done_o     (line_done)
    );

    miss_ctrl miss_ctrl_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .miss_i        (miss),
        .miss_addr_i   (alu_res_i),
        .line_done_i   (line_done),
        .mem_rd_req_o  (mem_rd_req_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .fill_we_o     (fill_we),
        .fill_addr_o   (fill_addr),
        .idle_o        (ctrl_idle)
    );

    // Each drained store is also one memory write
    assign mem_wr_o      = sb_port.drain_ack;
    assign mem_wr_addr_o = sb_port.drain_addr;
    assign mem_wr_data_o = sb_port.drain_data;
    assign mem_wr_mask_o = sb_port.drain_mask;

endmodule

// ==== test/tb_mem_top.sv ====
`timescale 1ns/1ns
`include "mem_cfg.svh"

module tb_mem_top;
    import mem_pkg::*;

    // Longest access covers detect, request, four beats with gaps, install and drain
    localparam int TOTAL_OPS       = 450;
    localparam int WORST_OP_CYCLES = 8 + `LINE_WORDS * 4 + `SB_DEPTH * 2;
    localparam int WATCHDOG_CYCLES = (TOTAL_OPS + 100) * WORST_OP_CYCLES;
    localparam int MEM_BYTES       = 1024;

    typedef struct packed {
        word_t     op_res;
        logic      rf_we;
        reg_addr_t waddr;
        logic      tkbr;
        word_t     new_pc;
    } wb_t;

    typedef struct packed {
        word_t addr;
        word_t data;
        mask_t mask;
    } wr_t;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    word_t       alu_res_i;
    word_t       rf_st_data_i;
    logic        rf_we_i;
    reg_addr_t   rf_waddr_i;
    logic        memop_rd_i;
    logic        memop_wr_i;
    memop_size_e memop_size_i;
    logic        memop_sign_ext_i;
    logic        tkbr_i;
    word_t       new_pc_i;
    word_t       op_res_o;
    logic        rf_we_o;
    reg_addr_t   rf_waddr_o;
    logic        tkbr_o;
    word_t       new_pc_o;
    logic        stall_o;
    logic        mem_rd_req_o;
    word_t       mem_rd_addr_o;
    logic        mem_beat_vld_i;
    word_t       mem_beat_data_i;
    logic        mem_wr_o;
    word_t       mem_wr_addr_o;
    word_t       mem_wr_data_o;
    mask_t       mem_wr_mask_o;

    integer      seed = 32'he197_2f36;
    string       test_name = "reset";
    logic [7:0]  mem_model [MEM_BYTES];
    logic [7:0]  shadow [MEM_BYTES];
    wb_t         wb_q [$];
    string       name_q [$];
    wr_t         store_q [$];
    int          req_count = 0;
    word_t       last_req_addr = '0;

    mem_top mem_top_inst (.*);

    always #5 clk_i = ~clk_i;

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %h, actual %h", test, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Run aborted");
    endtask

    // Initial memory contents depend on every address bit
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a) ^ (8'(a >> 8) * 8'h3b);
    endfunction

    function automatic word_t model_word(input word_t addr);
        int a;
        a = int'(addr[9:0]);
        return {mem_model[a + 3], mem_model[a + 2], mem_model[a + 1], mem_model[a]};
    endfunction

    function automatic word_t shadow_word(input int a);
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    endfunction

    // Each set mask bit selects all eight bits of its byte
    function automatic word_t lane_bits(input mask_t mask);
        word_t bits;
        for (int b = 0; b < 4; b++) begin
            bits[8*b +: 8] = {8{mask[b]}};
        end
        return bits;
    endfunction

    // Expected load value from program-order memory
    function automatic word_t ref_load(input word_t addr, input memop_size_e size,
                                       input logic sext);
        int         a;
        logic [7:0] b0;
        logic [7:0] b1;
        a  = int'(addr[9:0]);
        b0 = shadow[a];
        b1 = shadow[a + 1];
        case (size)
            BYTE:    return {{24{sext & b0[7]}}, b0};
            HALF:    return {{16{sext & b1[7]}}, b1, b0};
            default: return shadow_word(a);
        endcase
    endfunction

    task automatic apply_store(input word_t addr, input memop_size_e size, input word_t data);
        int  a;
        int  nbytes;
        int  lane;
        wr_t wr;
        a       = int'(addr[9:0]);
        nbytes  = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        wr.addr = {addr[31:2], 2'b00};
        wr.data = '0;
        wr.mask = '0;
        for (int i = 0; i < nbytes; i++) begin
            lane                 = (a + i) % 4;
            shadow[a + i]        = data[8*i +: 8];
            wr.mask[lane]        = 1'b1;
            wr.data[8*lane +: 8] = data[8*i +: 8];
        end
        store_q.push_back(wr);
    endtask

    task automatic drive_idle();
        memop_rd_i <= 1'b0;
        memop_wr_i <= 1'b0;
        rf_we_i    <= 1'b0;
        tkbr_i     <= 1'b0;
    endtask

    // Called at a rising edge and returns at the edge that accepts the operation
    task automatic issue_op(input logic rd, input logic wr, input memop_size_e size,
                            input logic sext, input word_t addr, input word_t st_data);
        wb_t   want;
        word_t rnd;
        rnd         = $random(seed);
        want.rf_we  = rnd[0];
        want.tkbr   = rnd[1];
        want.waddr  = rnd[6:2];
        want.new_pc = $random(seed);
        memop_rd_i       <= rd;
        memop_wr_i       <= wr;
        memop_size_i     <= size;
        memop_sign_ext_i <= sext;
        alu_res_i        <= addr;
        rf_st_data_i     <= st_data;
        rf_we_i          <= want.rf_we;
        rf_waddr_i       <= want.waddr;
        tkbr_i           <= want.tkbr;
        new_pc_i         <= want.new_pc;
        @(negedge clk_i);
        while (stall_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        if (wr) begin
            apply_store(addr, size, st_data);
        end
        want.op_res = rd ? ref_load(addr, size, sext) : addr;
        wb_q.push_back(want);
        name_q.push_back(test_name);
    endtask

    // Writeback is valid one cycle after acceptance
    always @(negedge clk_i) begin : compare_writeback
        wb_t   want;
        string name;
        if (wb_q.size() != 0) begin
            want = wb_q.pop_front();
            name = name_q.pop_front();
            check_value(name, "op_res_o", want.op_res, op_res_o);
            check_value(name, "rf_we_o", 32'(want.rf_we), 32'(rf_we_o));
            check_value(name, "rf_waddr_o", 32'(want.waddr), 32'(rf_waddr_o));
            check_value(name, "tkbr_o", 32'(want.tkbr), 32'(tkbr_o));
            check_value(name, "new_pc_o", want.new_pc, new_pc_o);
        end
    end

    always @(negedge clk_i) begin : write_monitor
        wr_t want;
        if (rst_n_i && mem_wr_o) begin
            if (store_q.size() == 0) begin
                report_failure("A memory write appeared with no store pending");
            end else begin
                want = store_q.pop_front();
                check_value(test_name, "mem_wr_addr_o", want.addr, mem_wr_addr_o);
                check_value(test_name, "mem_wr_mask_o", 32'(want.mask), 32'(mem_wr_mask_o));
                check_value(test_name, "mem_wr_data_o", want.data,
                            mem_wr_data_o & lane_bits(want.mask));
                for (int b = 0; b < 4; b++) begin
                    if (mem_wr_mask_o[b]) begin
                        mem_model[int'(mem_wr_addr_o[9:0]) + b] = mem_wr_data_o[8*b +: 8];
                    end
                end
            end
        end
    end

    always @(negedge clk_i) begin : request_monitor
        if (rst_n_i && mem_rd_req_o) begin
            req_count     = req_count + 1;
            last_req_addr = mem_rd_addr_o;
        end
    end

    // Line reads answered beat by beat with random gaps
    initial begin : memory_read_model
        word_t line_base;
        word_t rnd;
        int    gaps [`LINE_WORDS];
        mem_beat_vld_i  = 1'b0;
        mem_beat_data_i = '0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && mem_rd_req_o) begin
                line_base = mem_rd_addr_o;
                for (int i = 0; i < `LINE_WORDS; i++) begin
                    rnd     = $random(seed);
                    gaps[i] = int'(rnd[1:0]);
                end
                @(posedge clk_i);
                for (int i = 0; i < `LINE_WORDS; i++) begin
                    repeat (gaps[i]) begin
                        mem_beat_vld_i <= 1'b0;
                        @(posedge clk_i);
                    end
                    mem_beat_vld_i  <= 1'b1;
                    mem_beat_data_i <= model_word(line_base + word_t'(4 * i));
                    @(posedge clk_i);
                end
                mem_beat_vld_i <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        report_failure("Watchdog expired, the DUT stopped making progress");
    end

    initial begin : stimulus
        word_t       rnd;
        word_t       addr;
        word_t       line;
        memop_size_e size;
        int          reqs_before;
        rst_n_i          = 1'b0;
        alu_res_i        = '0;
        rf_st_data_i     = '0;
        rf_we_i          = 1'b0;
        rf_waddr_i       = '0;
        memop_rd_i       = 1'b0;
        memop_wr_i       = 1'b0;
        memop_size_i     = WORD;
        memop_sign_ext_i = 1'b0;
        tkbr_i           = 1'b0;
        new_pc_i         = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem_model[a] = fill_byte(a);
            shadow[a]    = fill_byte(a);
        end
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value(test_name, "rf_we_o", 32'd0, 32'(rf_we_o));
        check_value(test_name, "tkbr_o", 32'd0, 32'(tkbr_o));
        check_value(test_name, "stall_o", 32'd0, 32'(stall_o));
        check_value(test_name, "mem_rd_req_o", 32'd0, 32'(mem_rd_req_o));
        check_value(test_name, "mem_wr_o", 32'd0, 32'(mem_wr_o));
        @(posedge clk_i);

        test_name = "alu_pass";
        for (int i = 0; i < 8; i++) begin
            issue_op(1'b0, 1'b0, WORD, 1'b0, $random(seed), '0);
        end

        test_name   = "first_miss";
        reqs_before = req_count;
        issue_op(1'b1, 1'b0, WORD, 1'b0, 32'h0000_0048, '0);
        check_value(test_name, "read requests", 32'(reqs_before + 1), 32'(req_count));
        check_value(test_name, "mem_rd_addr_o", 32'h0000_0040, last_req_addr);
        issue_op(1'b1, 1'b0, HALF, 1'b1, 32'h0000_0046, '0);
        check_value(test_name, "read requests", 32'(reqs_before + 1), 32'(req_count));

        // One line of negative bytes and one of positive bytes
        test_name = "load_sizes";
        for (int l = 0; l < 2; l++) begin
            line = (l == 0) ? 32'h0000_0080 : 32'h0000_0020;
            for (int w = 0; w < 16; w += 4) begin
                for (int b = 0; b < 4; b++) begin
                    issue_op(1'b1, 1'b0, BYTE, 1'b1, line + word_t'(w + b), '0);
                    issue_op(1'b1, 1'b0, BYTE, 1'b0, line + word_t'(w + b), '0);
                    if (b % 2 == 0) begin
                        issue_op(1'b1, 1'b0, HALF, 1'b1, line + word_t'(w + b), '0);
                        issue_op(1'b1, 1'b0, HALF, 1'b0, line + word_t'(w + b), '0);
                    end
                end
                issue_op(1'b1, 1'b0, WORD, 1'b0, line + word_t'(w), '0);
            end
        end

        test_name = "store_forward";
        issue_op(1'b0, 1'b1, WORD, 1'b0, 32'h0000_0100, 32'hdead_beef);
        issue_op(1'b1, 1'b0, WORD, 1'b0, 32'h0000_0100, '0);
        issue_op(1'b0, 1'b1, BYTE, 1'b0, 32'h0000_0105, 32'h0000_0081);
        issue_op(1'b1, 1'b0, HALF, 1'b1, 32'h0000_0104, '0);
        issue_op(1'b0, 1'b1, HALF, 1'b0, 32'h0000_010a, 32'h0000_f00d);
        issue_op(1'b1, 1'b0, BYTE, 1'b1, 32'h0000_010b, '0);
        issue_op(1'b0, 1'b1, BYTE, 1'b0, 32'h0000_010c, 32'h0000_007f);
        issue_op(1'b0, 1'b1, BYTE, 1'b0, 32'h0000_010d, 32'h0000_0080);
        issue_op(1'b1, 1'b0, WORD, 1'b0, 32'h0000_010c, '0);

        // 512 bytes over a 256 byte cache keeps misses coming
        test_name = "random_mix";
        for (int i = 0; i < 300; i++) begin
            rnd  = $random(seed);
            addr = {23'd0, rnd[8:0]};
            case (rnd[10:9])
                2'd0:    size = BYTE;
                2'd1:    size = HALF;
                default: size = WORD;
            endcase
            if (size == HALF) begin
                addr[0] = 1'b0;
            end else if (size == WORD) begin
                addr[1:0] = 2'b00;
            end
            if (rnd[13:11] == 3'd0) begin
                issue_op(1'b0, 1'b0, WORD, 1'b0, $random(seed), '0);
            end else if (rnd[13:11] < 3'd4) begin
                issue_op(1'b0, 1'b1, size, 1'b0, addr, $random(seed));
            end else begin
                issue_op(1'b1, 1'b0, size, rnd[14], addr, '0);
            end
        end

        test_name = "final_memory";
        drive_idle();
        while (store_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);
        for (int a = 0; a < MEM_BYTES; a += 4) begin
            check_value(test_name, $sformatf("memory word %h", a), shadow_word(a),
                        model_word(word_t'(a)));
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+source
source/mem_pkg.sv
source/mem_ifs.sv
source/dcache_array.sv
source/store_buffer.sv
source/beat_counter.sv
source/miss_ctrl.sv
source/mem_stage.sv
source/mem_top.sv
test/tb_mem_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
